/* rtl/wd_cmd_decode.sv */
//------------------------------
// Command decode stage
// Latches a host command while idle, classifies the code
// and offers it to the sequencer by req/ack
//------------------------------

`timescale 1ns/1ns

module wd_cmd_decode (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic [7:0]                cmd_code,
    input  logic                      cmd_valid,
    input  logic [wd_pkg::CYL_W-1:0]  cylinder,
    input  logic [wd_pkg::HEAD_W-1:0] head,
    input  logic [wd_pkg::SECT_W-1:0] sector_num,
    input  logic [wd_pkg::SECT_W-1:0] sector_count,
    wd_cmd_if.issuer                  cmd,
    wd_status_if.gate                 stat
);
    import wd_pkg::*;

    wd_op_e op_next;
    logic   accept;

    // New command only when idle and no offer outstanding
    assign accept = cmd_valid && !stat.busy && !cmd.req;

    // Code classification
    always_comb begin
        if ((cmd_code & 8'hF0) == CMD_RESTORE) op_next = OP_RESTORE;  // Low nibble is step rate
        else if ((cmd_code & 8'hF0) == CMD_SEEK) op_next = OP_SEEK;
        else if (cmd_code == CMD_READ)   op_next = OP_READ;
        else if (cmd_code == CMD_WRITE)  op_next = OP_WRITE;
        else if (cmd_code == CMD_VERIFY) op_next = OP_VERIFY;
        else                             op_next = OP_INVALID;   // Aborted later
    end

    // Handshake half, req up on accept and down on ack
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cmd.req <= 1'b0;
        end else if (accept) begin
            cmd.req <= 1'b1;
        end else if (cmd.ack) begin
            cmd.req <= 1'b0;
        end
    end

    // Command fields
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd.op       <= op_next;
            cmd.cylinder <= cylinder;
            cmd.head     <= head;
            cmd.sector   <= sector_num;
            cmd.count    <= sector_count;
        end
    end

    // Offer held with stable fields until taken
    a_req_hold: assert property (@(posedge clk) disable iff (!reset_n)
        cmd.req && !cmd.ack |=> cmd.req && $stable(cmd.op) && $stable(cmd.cylinder)
            && $stable(cmd.head) && $stable(cmd.sector) && $stable(cmd.count));

endmodule

/* rtl/wd_cmd_if.sv */
//------------------------------
// Decoded command bus, decode to execute
// Four-phase req/ack, fields stable while req is high
//------------------------------

`timescale 1ns/1ns

interface wd_cmd_if;
    import wd_pkg::*;

    logic               req;      // Command offered
    logic               ack;      // Fields copied by execute
    wd_op_e             op;
    logic [CYL_W-1:0]   cylinder;
    logic [HEAD_W-1:0]  head;
    logic [SECT_W-1:0]  sector;   // Starting sector
    logic [SECT_W-1:0]  count;    // 0 and 1 both mean one sector

    modport issuer (output req, op, cylinder, head, sector, count, input ack);
    modport taker  (input req, op, cylinder, head, sector, count, output ack);
    modport watch  (input req, ack);

endinterface

/* rtl/wd_ctrl_top.sv */
//------------------------------
// Disk controller command sequencer top
// Decode, execute and result stages on two internal buses
//------------------------------

`timescale 1ns/1ns

module wd_ctrl_top (
    input  logic                      clk,
    input  logic                      reset_n,
    // Host command
    input  logic [7:0]                cmd_code,
    input  logic                      cmd_valid,
    input  logic [wd_pkg::CYL_W-1:0]  cylinder,
    input  logic [wd_pkg::HEAD_W-1:0] head,
    input  logic [wd_pkg::SECT_W-1:0] sector_num,
    input  logic [wd_pkg::SECT_W-1:0] sector_count,
    // Status
    input  logic                      drive_ready,
    output logic                      status_bsy,
    output logic                      status_rdy,
    output logic                      status_sc,
    output logic                      status_drq,
    output logic                      status_err,
    output wd_pkg::wd_err_e           error_code,
    // Seek controller
    output logic                      seek_start,
    output logic                      recalibrate,
    output logic [wd_pkg::CYL_W-1:0]  target_cylinder,
    input  logic                      seek_done,
    input  logic                      seek_error,
    input  logic                      track00,
    // Track buffer
    output logic                      buf_fill_start,
    output logic                      buf_flush_start,
    output logic [wd_pkg::SECT_W-1:0] buf_target_sector,
    output logic [wd_pkg::HEAD_W-1:0] buf_target_head,
    input  logic                      buf_ready,
    input  logic                      buf_error,
    // Host transfer engine
    output logic                      xfer_start,
    output logic                      xfer_dir,
    input  logic                      xfer_done
);

    wd_cmd_if    cmd_bus ();
    wd_status_if stat_bus ();

    wd_cmd_decode u_decode (
        .clk, .reset_n, .cmd_code, .cmd_valid,
        .cylinder, .head, .sector_num, .sector_count,
        .cmd (cmd_bus.issuer), .stat (stat_bus.gate)
    );

    wd_sector_sequencer u_seq (
        .clk, .reset_n,
        .cmd (cmd_bus.taker), .stat (stat_bus.reporter),
        .seek_start, .recalibrate, .target_cylinder,
        .seek_done, .seek_error, .track00,
        .buf_fill_start, .buf_flush_start, .buf_target_sector, .buf_target_head,
        .buf_ready, .buf_error,
        .xfer_start, .xfer_dir, .xfer_done
    );

    wd_status_result u_result (
        .clk, .reset_n, .drive_ready,
        .cmd (cmd_bus.watch), .stat (stat_bus.holder),
        .status_bsy, .status_rdy, .status_sc, .status_drq, .status_err, .error_code
    );

endmodule

/* rtl/wd_pkg.sv */
//------------------------------
// Shared definitions for the disk controller command path:
// field widths, command codes, decoded ops and error values
//------------------------------

package wd_pkg;

    //------------------------------
    // Field widths
    //------------------------------
    localparam int CYL_W  = 16;   // Cylinder
    localparam int HEAD_W = 4;    // Head select
    localparam int SECT_W = 8;    // Sector number and count

    // Host command codes, RESTORE and SEEK are range bases
    typedef enum logic [7:0] {
        CMD_RESTORE = 8'h10,      // 0x10 to 0x1F
        CMD_READ    = 8'h20,
        CMD_WRITE   = 8'h30,
        CMD_VERIFY  = 8'h40,
        CMD_SEEK    = 8'h70       // 0x70 to 0x7F
    } wd_cmd_e;

    // Decoded operation
    typedef enum logic [2:0] {
        OP_RESTORE,
        OP_SEEK,
        OP_READ,
        OP_WRITE,
        OP_VERIFY,
        OP_INVALID
    } wd_op_e;

    // AT error register values
    typedef enum logic [7:0] {
        ERR_NONE  = 8'h00,
        ERR_AMNF  = 8'h01,        // Address mark not found
        ERR_TK0NF = 8'h02,        // Track 0 not found
        ERR_ABRT  = 8'h04,        // Aborted command
        ERR_IDNF  = 8'h10         // ID not found
    } wd_err_e;

    // Sequencer FSM
    typedef enum logic [3:0] {
        ST_IDLE, ST_RELEASE, ST_SEEK_WAIT, ST_SECTOR, ST_FILL_WAIT,
        ST_XFER_WAIT, ST_FLUSH_WAIT, ST_NEXT, ST_DONE
    } wd_seq_state_e;

endpackage

/* rtl/wd_sector_sequencer.sv */
//------------------------------
// Execute stage
// Seeks, then runs buffer and host transfer steps
// one sector at a time, reports the error value at done
//------------------------------

`timescale 1ns/1ns

module wd_sector_sequencer (
    input  logic                      clk,
    input  logic                      reset_n,
    wd_cmd_if.taker                   cmd,
    wd_status_if.reporter             stat,
    output logic                      seek_start,
    output logic                      recalibrate,
    output logic [wd_pkg::CYL_W-1:0]  target_cylinder,
    input  logic                      seek_done,
    input  logic                      seek_error,
    input  logic                      track00,
    output logic                      buf_fill_start,
    output logic                      buf_flush_start,
    output logic [wd_pkg::SECT_W-1:0] buf_target_sector,
    output logic [wd_pkg::HEAD_W-1:0] buf_target_head,
    input  logic                      buf_ready,
    input  logic                      buf_error,
    output logic                      xfer_start,
    output logic                      xfer_dir,
    input  logic                      xfer_done
);
    import wd_pkg::*;

    wd_seq_state_e     state;
    wd_op_e            op_q;
    logic [CYL_W-1:0]  cyl_q;
    logic [HEAD_W-1:0] head_q;
    logic [SECT_W-1:0] cur_sector;
    logic [SECT_W-1:0] remaining;
    logic              is_restore;
    logic              more;

    assign is_restore = (op_q == OP_RESTORE);
    assign more       = (remaining > SECT_W'(1));   // Count 0 acts as 1
    assign stat.done  = (state == ST_DONE);

    //------------------------------
    // Command copy and sector counters
    //------------------------------
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cmd.req) begin
            op_q       <= cmd.op;
            cyl_q      <= cmd.cylinder;
            head_q     <= cmd.head;
            cur_sector <= cmd.sector;
            remaining  <= cmd.count;
        end else if (state == ST_NEXT && more) begin
            remaining  <= remaining - SECT_W'(1);
            cur_sector <= cur_sector + SECT_W'(1);
        end
        if (state == ST_RELEASE && !cmd.req)
            target_cylinder <= is_restore ? '0 : cyl_q;   // Restore goes to cylinder 0
        if (state == ST_SECTOR) begin
            buf_target_sector <= cur_sector;   // Also kept for the flush
            buf_target_head   <= head_q;
        end
    end

    //------------------------------
    // Main FSM
    //------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state              <= ST_IDLE;
            cmd.ack            <= 1'b0;
            seek_start         <= 1'b0;
            recalibrate        <= 1'b0;
            buf_fill_start     <= 1'b0;
            buf_flush_start    <= 1'b0;
            xfer_start         <= 1'b0;
            xfer_dir           <= 1'b0;
            stat.drq           <= 1'b0;
            stat.seek_complete <= 1'b1;
            stat.err           <= ERR_NONE;
        end else begin
            seek_start      <= 1'b0;   // Start pulses default low
            buf_fill_start  <= 1'b0;
            buf_flush_start <= 1'b0;
            xfer_start      <= 1'b0;
            unique case (state)
                ST_IDLE: if (cmd.req) begin
                    cmd.ack  <= 1'b1;        // Fields copied this edge
                    stat.err <= ERR_NONE;
                    state    <= ST_RELEASE;
                end
                ST_RELEASE: if (!cmd.req) begin
                    cmd.ack <= 1'b0;         // Handshake closed before any step
                    if (op_q == OP_INVALID) begin
                        stat.err <= ERR_ABRT;    // No seek for unknown codes
                        state    <= ST_DONE;
                    end else begin
                        seek_start         <= 1'b1;
                        recalibrate        <= is_restore;
                        stat.seek_complete <= 1'b0;
                        state              <= ST_SEEK_WAIT;
                    end
                end
                ST_SEEK_WAIT: begin
                    if (seek_error || (seek_done && is_restore && !track00)) begin
                        stat.err <= is_restore ? ERR_TK0NF : ERR_IDNF;   // SC stays low
                        state    <= ST_DONE;
                    end else if (seek_done) begin
                        stat.seek_complete <= 1'b1;
                        if (op_q == OP_READ || op_q == OP_WRITE) state <= ST_SECTOR;
                        else                                   state <= ST_DONE;
                    end
                end
                ST_SECTOR: begin
                    if (op_q == OP_READ) begin
                        buf_fill_start <= 1'b1;  // Disk to buffer first
                        state          <= ST_FILL_WAIT;
                    end else begin
                        xfer_start <= 1'b1;      // Host data first on write
                        xfer_dir   <= 1'b1;
                        stat.drq   <= 1'b1;
                        state      <= ST_XFER_WAIT;
                    end
                end
                ST_FILL_WAIT: begin
                    if (buf_error) begin
                        stat.err <= ERR_AMNF;
                        state    <= ST_DONE;
                    end else if (buf_ready) begin
                        xfer_start <= 1'b1;
                        xfer_dir   <= 1'b0;      // Buffer to host
                        stat.drq   <= 1'b1;
                        state      <= ST_XFER_WAIT;
                    end
                end
                ST_XFER_WAIT: if (xfer_done) begin
                    stat.drq <= 1'b0;
                    if (op_q == OP_WRITE) begin
                        buf_flush_start <= 1'b1;
                        state           <= ST_FLUSH_WAIT;
                    end else begin
                        state <= ST_NEXT;
                    end
                end
                ST_FLUSH_WAIT: begin
                    if (buf_error) begin
                        stat.err <= ERR_AMNF;
                        state    <= ST_DONE;
                    end else if (buf_ready) begin
                        state <= ST_NEXT;
                    end
                end
                ST_NEXT: state <= more ? ST_SECTOR : ST_DONE;
                ST_DONE: state <= ST_IDLE;   // done pulse is this state
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Start pulses are single cycle
    a_seek_pulse:  assert property (@(posedge clk) disable iff (!reset_n)
        seek_start |=> !seek_start);
    a_fill_pulse:  assert property (@(posedge clk) disable iff (!reset_n)
        buf_fill_start |=> !buf_fill_start);
    a_flush_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        buf_flush_start |=> !buf_flush_start);
    a_xfer_pulse:  assert property (@(posedge clk) disable iff (!reset_n)
        xfer_start |=> !xfer_start);
    a_fill_flush:  assert property (@(posedge clk) disable iff (!reset_n)
        !(buf_fill_start && buf_flush_start));

endmodule

/* rtl/wd_status_if.sv */
//------------------------------
// Completion and live status bus between
// execute, result and decode stages
//------------------------------

`timescale 1ns/1ns

interface wd_status_if;
    import wd_pkg::*;

    logic    done;            // One cycle at command end
    wd_err_e err;             // Valid with done
    logic    drq;             // Host transfer in progress
    logic    seek_complete;
    logic    busy;            // Owned by result stage

    modport reporter (output done, err, drq, seek_complete);
    modport holder   (output busy, input done, err, drq, seek_complete);
    modport gate     (input busy);

endinterface

/* rtl/wd_status_result.sv */
//------------------------------
// Result stage
// Owns busy and holds the AT status bits and error register
//------------------------------

`timescale 1ns/1ns

module wd_status_result (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            drive_ready,
    wd_cmd_if.watch         cmd,
    wd_status_if.holder     stat,
    output logic            status_bsy,
    output logic            status_rdy,
    output logic            status_sc,
    output logic            status_drq,
    output logic            status_err,
    output wd_pkg::wd_err_e error_code
);
    import wd_pkg::*;

    logic req_q;
    logic req_rise;
    logic busy_next;

    assign req_rise   = cmd.req && !req_q;   // New command offered
    assign status_bsy = stat.busy;

    always_comb begin
        busy_next = stat.busy;
        if (req_rise)  busy_next = 1'b1;
        if (stat.done) busy_next = 1'b0;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            req_q      <= 1'b0;
            stat.busy  <= 1'b0;
            status_rdy <= 1'b0;
            status_sc  <= 1'b1;
            status_drq <= 1'b0;
            status_err <= 1'b0;
            error_code <= ERR_NONE;
        end else begin
            req_q      <= cmd.req;
            stat.busy  <= busy_next;
            status_rdy <= drive_ready && !busy_next;   // Forced low while busy
            status_sc  <= stat.seek_complete;
            status_drq <= stat.drq;
            if (req_rise) begin
                status_err <= 1'b0;      // Previous result cleared
                error_code <= ERR_NONE;
            end else if (stat.done) begin
                status_err <= (stat.err != ERR_NONE);
                error_code <= stat.err;
            end
        end
    end

    // Completion only inside a busy window
    a_done_busy: assert property (@(posedge clk) disable iff (!reset_n)
        stat.done |-> stat.busy);
    // Sequencer ack only after busy is up
    a_ack_busy:  assert property (@(posedge clk) disable iff (!reset_n)
        cmd.ack |-> stat.busy);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the disk controller testbench with Verilator, run it, grep the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f wd_ctrl.f --top-module tb_wd_ctrl -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "Build or simulation run did not complete" >> sim.log

cat sim.log
grep -qx ">>> PASS" sim.log && exit 0 || exit 1

/* tb/tb_wd_ctrl.sv */
//------------------------------
// Testbench for the disk controller command sequencer
// Table driven commands against a drive model
//------------------------------

`timescale 1ns/1ns

module tb_wd_ctrl;
    import wd_pkg::*;

    localparam logic [1:0] INJ_NONE = 2'd0;
    localparam logic [1:0] INJ_SEEK = 2'd1;
    localparam logic [1:0] INJ_TK0  = 2'd2;
    localparam logic [1:0] INJ_BUF  = 2'd3;

    typedef struct packed {
        logic [7:0]        code;
        logic [CYL_W-1:0]  cyl;
        logic [HEAD_W-1:0] head;
        logic [SECT_W-1:0] sect;
        logic [SECT_W-1:0] cnt;
        logic [1:0]        inj;
        logic [3:0]        inj_k;     // Failing buffer op
        wd_err_e           err;
        logic [3:0]        fills;
        logic [3:0]        xfers;
        logic [3:0]        flushes;
    } row_t;

    logic clk, reset_n, cmd_valid, drive_ready, log_clear;
    logic [7:0]        cmd_code;
    logic [CYL_W-1:0]  cylinder, target_cylinder;
    logic [HEAD_W-1:0] head, buf_target_head;
    logic [SECT_W-1:0] sector_num, sector_count, buf_target_sector;
    logic status_bsy, status_rdy, status_sc, status_drq, status_err;
    wd_err_e error_code;
    logic seek_start, recalibrate, seek_done, seek_error, track00;
    logic buf_fill_start, buf_flush_start, buf_ready, buf_error;
    logic xfer_start, xfer_dir, xfer_done;
    logic [1:0] inject;
    logic [3:0] err_k;

    row_t rows[$];
    int   errors, checks, cycles, limit, drq_hits;

    wd_ctrl_top    dut (.*);
    wd_drive_model model (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: run passed %0d cycles without finishing", limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    // status_drq must be up whenever a transfer answers
    always @(posedge clk)
        if (xfer_done && status_drq) drq_hits <= drq_hits + 1;

    //------------------------------
    // Compare tasks
    //------------------------------
    task automatic check_err(input string name, input wd_err_e got, input wd_err_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %0t %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_sector(input string name, input logic [SECT_W-1:0] got,
                                input logic [SECT_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Error %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic add_row(input logic [7:0] code, input logic [CYL_W-1:0] cyl,
                           input logic [HEAD_W-1:0] hd, input logic [SECT_W-1:0] sect,
                           input logic [SECT_W-1:0] cnt, input logic [1:0] inj,
                           input logic [3:0] k, input wd_err_e err, input logic [3:0] fl,
                           input logic [3:0] xf, input logic [3:0] fs);
        rows.push_back({code, cyl, hd, sect, cnt, inj, k, err, fl, xf, fs});
    endtask

    // Command table, code cyl head sector count inject k error fills xfers flushes
    task automatic load_table();
        add_row(8'h13, 500, 0, 0, 0, INJ_NONE, 0, ERR_NONE, 0, 0, 0);
        add_row(8'h72, 1234, 0, 0, 0, INJ_NONE, 0, ERR_NONE, 0, 0, 0);
        add_row(CMD_READ, 100, 3, 5, 4, INJ_NONE, 0, ERR_NONE, 4, 4, 0);
        add_row(CMD_WRITE, 200, 7, 250, 3, INJ_NONE, 0, ERR_NONE, 0, 3, 3);
        add_row(CMD_READ, 42, 15, 9, 0, INJ_NONE, 0, ERR_NONE, 1, 1, 0);
        add_row(CMD_VERIFY, 77, 2, 1, 6, INJ_NONE, 0, ERR_NONE, 0, 0, 0);
        add_row(8'h7F, 900, 0, 0, 0, INJ_SEEK, 0, ERR_IDNF, 0, 0, 0);
        add_row(CMD_VERIFY, 65535, 1, 1, 2, INJ_SEEK, 0, ERR_IDNF, 0, 0, 0);
        add_row(CMD_RESTORE, 10, 0, 0, 0, INJ_TK0, 0, ERR_TK0NF, 0, 0, 0);
        add_row(CMD_READ, 300, 4, 20, 5, INJ_BUF, 3, ERR_AMNF, 3, 2, 0);
        add_row(CMD_WRITE, 301, 5, 30, 3, INJ_BUF, 2, ERR_AMNF, 0, 2, 2);
        add_row(8'h22, 1, 1, 1, 1, INJ_NONE, 0, ERR_ABRT, 0, 0, 0);
        add_row(8'h50, 1, 1, 1, 1, INJ_NONE, 0, ERR_ABRT, 0, 0, 0);
        add_row(8'h90, 1, 1, 1, 1, INJ_NONE, 0, ERR_ABRT, 0, 0, 0);
        add_row(8'hEC, 1, 1, 1, 1, INJ_NONE, 0, ERR_ABRT, 0, 0, 0);
    endtask

    task automatic run_row(input row_t row, input int idx);
        logic rdy;
        logic restore;
        int   n;
        rdy     = ((idx % 3) != 0);
        restore = (row.code[7:4] == 4'h1);
        @(posedge clk);
        inject      <= row.inj;
        err_k       <= row.inj_k;
        drive_ready <= rdy;
        log_clear   <= 1'b1;
        @(posedge clk);
        log_clear    <= 1'b0;
        cmd_code     <= row.code;
        cylinder     <= row.cyl;
        head         <= row.head;
        sector_num   <= row.sect;
        sector_count <= row.cnt;
        cmd_valid    <= 1'b1;
        drq_hits     <= 0;
        @(posedge clk);
        cmd_valid <= 1'b0;
        #1;
        while (!status_bsy) begin
            @(posedge clk);
            #1;
        end
        check_bit("status_rdy", status_rdy, 1'b0);
        // Stray command while busy must be ignored
        @(posedge clk);
        cmd_code  <= CMD_READ;
        cmd_valid <= 1'b1;
        @(posedge clk);
        cmd_valid <= 1'b0;
        #1;
        while (status_bsy) begin
            @(posedge clk);
            #1;
        end
        repeat (3) @(posedge clk);
        #1;
        check_err("error_code", error_code, row.err);
        check_bit("status_err", status_err, row.err != ERR_NONE);
        check_bit("status_sc", status_sc, !(row.err == ERR_IDNF || row.err == ERR_TK0NF));
        check_bit("status_drq", status_drq, 1'b0);
        check_bit("status_rdy", status_rdy, rdy);
        check_count("seek pulses", model.seek_cyl_q.size(), row.err == ERR_ABRT ? 0 : 1);
        if (model.seek_cyl_q.size() == 1) begin
            check_bit("recalibrate", model.recal_q[0], restore);
            check_count("target_cylinder", int'(model.seek_cyl_q[0]),
                        restore ? 0 : int'(row.cyl));
        end
        check_count("fill pulses", model.fill_sect_q.size(), int'(row.fills));
        check_count("xfer pulses", model.xfer_dir_q.size(), int'(row.xfers));
        check_count("flush pulses", model.flush_sect_q.size(), int'(row.flushes));
        check_count("drq during xfer", drq_hits, int'(row.xfers));
        foreach (model.fill_sect_q[i]) begin
            check_sector("fill sector", model.fill_sect_q[i], SECT_W'(int'(row.sect) + i));
            check_count("fill head", int'(model.fill_head_q[i]), int'(row.head));
        end
        foreach (model.flush_sect_q[i])
            check_sector("flush sector", model.flush_sect_q[i], SECT_W'(int'(row.sect) + i));
        foreach (model.xfer_dir_q[i])
            check_bit("xfer_dir", model.xfer_dir_q[i], row.code == CMD_WRITE);
        // Read alternates fill and xfer, write alternates xfer and flush
        foreach (model.ev_q[i]) begin
            n = (row.code == CMD_WRITE) ? 2 + (i % 2) : (i % 2);
            check_count("pulse order", int'(model.ev_q[i]), n);
        end
    endtask

    //------------------------------
    // Main sequence
    //------------------------------
    initial begin
        reset_n      = 1'b0;
        cmd_valid    = 1'b0;
        cmd_code     = 8'h00;
        cylinder     = '0;
        head         = '0;
        sector_num   = '0;
        sector_count = '0;
        drive_ready  = 1'b1;
        log_clear    = 1'b0;
        inject       = INJ_NONE;
        err_k        = 4'd0;
        errors       = 0;
        checks       = 0;
        limit        = 0;
        load_table();
        limit = 8;
        foreach (rows[r])
            limit += ((rows[r].cnt > 1 ? int'(rows[r].cnt) : 1) + 2) * 40;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        repeat (2) @(posedge clk);
        foreach (rows[r]) run_row(rows[r], r);
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* tb/wd_drive_model.sv */
//------------------------------
// Drive side model
// Seek controller, track buffer and transfer engine with
// LFSR answer delays, error injection and pulse logs
//------------------------------

`timescale 1ns/1ns

module wd_drive_model (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      log_clear,   // Empties all logs
    input  logic [1:0]                inject,      // 0 none, 1 seek, 2 no track00, 3 buffer
    input  logic [3:0]                err_k,       // Buffer op that fails, from 1
    input  logic                      seek_start,
    input  logic                      recalibrate,
    input  logic [wd_pkg::CYL_W-1:0]  target_cylinder,
    output logic                      seek_done,
    output logic                      seek_error,
    output logic                      track00,
    input  logic                      buf_fill_start,
    input  logic                      buf_flush_start,
    input  logic [wd_pkg::SECT_W-1:0] buf_target_sector,
    input  logic [wd_pkg::HEAD_W-1:0] buf_target_head,
    output logic                      buf_ready,
    output logic                      buf_error,
    input  logic                      xfer_start,
    input  logic                      xfer_dir,
    output logic                      xfer_done
);
    import wd_pkg::*;

    logic [7:0] lfsr;
    logic [3:0] dly;
    logic [3:0] wait_cnt;
    logic [1:0] pend;          // 0 idle, 1 seek, 2 buffer, 3 transfer
    logic       pend_err;
    logic [1:0]        ev_q[$];          // 0 fill, 1 xfer in, 2 xfer out, 3 flush
    logic [CYL_W-1:0]  seek_cyl_q[$];
    logic              recal_q[$];
    logic [SECT_W-1:0] fill_sect_q[$];
    logic [HEAD_W-1:0] fill_head_q[$];
    logic [SECT_W-1:0] flush_sect_q[$];
    logic              xfer_dir_q[$];

    assign track00 = (inject != 2'd2);

    // Fibonacci LFSR, taps 8 6 5 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lfsr = 8'd90;
            pend       <= 2'd0;
            wait_cnt   <= 4'd0;
            pend_err   <= 1'b0;
            seek_done  <= 1'b0;
            seek_error <= 1'b0;
            buf_ready  <= 1'b0;
            buf_error  <= 1'b0;
            xfer_done  <= 1'b0;
        end else begin
            seek_done  <= 1'b0;      // Answers last one cycle
            seek_error <= 1'b0;
            buf_ready  <= 1'b0;
            buf_error  <= 1'b0;
            xfer_done  <= 1'b0;
            if (log_clear) begin
                ev_q.delete();
                seek_cyl_q.delete();
                recal_q.delete();
                fill_sect_q.delete();
                fill_head_q.delete();
                flush_sect_q.delete();
                xfer_dir_q.delete();
            end
            if (pend != 2'd0) begin
                if (wait_cnt > 4'd1) begin
                    wait_cnt <= wait_cnt - 4'd1;
                end else begin
                    case (pend)
                        2'd1:    if (pend_err) seek_error <= 1'b1; else seek_done <= 1'b1;
                        2'd2:    if (pend_err) buf_error <= 1'b1; else buf_ready <= 1'b1;
                        default: xfer_done <= 1'b1;
                    endcase
                    pend <= 2'd0;
                end
            end
            if (seek_start || buf_fill_start || buf_flush_start || xfer_start) begin
                dly = 4'd0;
                for (int b = 0; b < 3; b++) begin   // One step per delay bit
                    lfsr = lfsr_next(lfsr);
                    dly  = {dly[2:0], lfsr[0]};
                end
                wait_cnt <= dly + 4'd1;          // 1 to 8 cycles
                pend_err <= 1'b0;
            end
            if (seek_start) begin
                pend     <= 2'd1;
                pend_err <= (inject == 2'd1);
                seek_cyl_q.push_back(target_cylinder);
                recal_q.push_back(recalibrate);
            end
            if (buf_fill_start || buf_flush_start) begin
                pend     <= 2'd2;
                pend_err <= (inject == 2'd3) &&
                    (fill_sect_q.size() + flush_sect_q.size() + 1 == int'(err_k));
                if (buf_fill_start) begin
                    ev_q.push_back(2'd0);
                    fill_sect_q.push_back(buf_target_sector);
                    fill_head_q.push_back(buf_target_head);
                end else begin
                    ev_q.push_back(2'd3);
                    flush_sect_q.push_back(buf_target_sector);
                end
            end
            if (xfer_start) begin
                pend <= 2'd3;
                ev_q.push_back(xfer_dir ? 2'd2 : 2'd1);
                xfer_dir_q.push_back(xfer_dir);
            end
        end
    end

endmodule

/* wd_ctrl.f */
rtl/wd_pkg.sv
rtl/wd_cmd_if.sv
rtl/wd_status_if.sv
rtl/wd_cmd_decode.sv
rtl/wd_sector_sequencer.sv
rtl/wd_status_result.sv
rtl/wd_ctrl_top.sv
tb/wd_drive_model.sv
tb/tb_wd_ctrl.sv
